// File: keypad_pkg.sv
`default_nettype none

package keypad_pkg;

  // Row nibble in [7:4], column nibble in [3:0]
  // Both one-hot, row 0 and column 0 on bit 3 of their nibble
  typedef logic [7:0] key_code_t;
  typedef logic [7:0] ascii_t;

  // Multi-tap position, DONE lasts one cycle after submit
  typedef enum logic [2:0] {
    INIT = 3'd0,
    S0   = 3'd1,
    S1   = 3'd2,
    S2   = 3'd3,
    S3   = 3'd4,
    DONE = 3'd5
  } tap_state_t;

  // Control keys
  localparam key_code_t KEY_SUBMIT_LETTER = 8'b0001_1000;
  localparam key_code_t KEY_CLEAR         = 8'b0001_0100;
  localparam key_code_t KEY_SUBMIT_WORD   = 8'b0001_0010;
  localparam key_code_t KEY_GAME_END      = 8'b0010_0001;

  // Letter keys with four letters
  localparam key_code_t KEY_7 = 8'b0010_1000;
  localparam key_code_t KEY_9 = 8'b0010_0010;

  // Keys with no function
  localparam key_code_t KEY_1 = 8'b1000_1000;
  localparam key_code_t KEY_A = 8'b1000_0001;
  localparam key_code_t KEY_B = 8'b0100_0001;
  localparam key_code_t KEY_D = 8'b0001_0001;

  // ASCII letter for a key at a given tap position
  function automatic ascii_t letter_for(key_code_t key, tap_state_t tap);
    ascii_t base;
    ascii_t offset;
    case (key)
      8'b1000_0100: base = 8'd65;
      8'b1000_0010: base = 8'd68;
      8'b0100_1000: base = 8'd71;
      8'b0100_0100: base = 8'd74;
      8'b0100_0010: base = 8'd77;
      KEY_7:        base = 8'd80;
      8'b0010_0100: base = 8'd84;
      KEY_9:        base = 8'd87;
      default:      base = 8'd0;
    endcase
    case (tap)
      S1:      offset = 8'd1;
      S2:      offset = 8'd2;
      S3:      offset = 8'd3;
      default: offset = 8'd0;
    endcase
    // Non-letter codes stay at zero
    return (base == 8'd0) ? 8'd0 : base + offset;
  endfunction

endpackage

`default_nettype wire

// File: letter_if.sv
`timescale 1ns/10ps
`default_nettype none

interface letter_if;

  // One-cycle pulse, letter valid on data
  logic                ready;
  // Preview letter, submitted letter while ready is high
  keypad_pkg::ascii_t  data;
  // Finish the current word
  logic                word_submit;
  // Discard the word and end the game
  logic                game_end;

  modport producer (
    output ready,
    output data,
    output word_submit,
    output game_end
  );

  modport consumer (
    input ready,
    input data,
    input word_submit,
    input game_end
  );

endinterface

`default_nettype wire

// File: keypad_scanner.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_scanner #(
  parameter int SCAN_DWELL     = 4,
  parameter int DEBOUNCE_SCANS = 2
) (
  input  logic                  clk,
  input  logic                  nRst,
  input  logic [3:0]            row,
  output logic [3:0]            col,
  output keypad_pkg::key_code_t cur_key,
  output logic                  strobe
);

  localparam int DW = (SCAN_DWELL > 1) ? $clog2(SCAN_DWELL) : 1;
  localparam int CW = $clog2(DEBOUNCE_SCANS + 1);
  localparam logic [DW-1:0] DWELL_LAST = DW'(SCAN_DWELL - 1);
  localparam logic [CW-1:0] DEB_LAST   = CW'(DEBOUNCE_SCANS - 1);

  logic [DW-1:0]         dwell_cnt;
  logic [CW-1:0]         press_cnt;
  logic [CW-1:0]         rel_cnt;
  logic [CW-1:0]         agree;
  keypad_pkg::key_code_t cand_key;
  keypad_pkg::key_code_t key_seen;
  logic                  held;
  logic                  sample;
  logic                  row_single;

  // Row settles over the dwell, sample at its end
  assign sample = (dwell_cnt == DWELL_LAST);

  // Exactly one row bit, two keys in one column are ignored
  assign row_single = (row != 4'b0000) && ((row & (row - 4'b0001)) == 4'b0000);

  assign key_seen = {row, col};

  // Agreement count so far for this key, zero if it is a new one
  assign agree = (key_seen == cand_key) ? press_cnt : '0;

  always_ff @(posedge clk or negedge nRst) begin
    if (!nRst) begin
      dwell_cnt <= '0;
      col       <= 4'b1000;
      press_cnt <= '0;
      rel_cnt   <= '0;
      cand_key  <= '0;
      held      <= 1'b0;
      cur_key   <= '0;
      strobe    <= 1'b0;
    end else begin
      strobe    <= 1'b0;
      dwell_cnt <= sample ? '0 : dwell_cnt + 1'b1;
      if (!held) begin
        if (sample) begin
          if (row_single && (agree == DEB_LAST)) begin
            // Press accepted, freeze on this column
            held      <= 1'b1;
            cur_key   <= key_seen;
            strobe    <= 1'b1;
            press_cnt <= '0;
            rel_cnt   <= '0;
            cand_key  <= '0;
          end else begin
            if (row_single) begin
              cand_key  <= key_seen;
              press_cnt <= agree + 1'b1;
            end else if (col == cand_key[3:0]) begin
              // Candidate column went quiet
              cand_key  <= '0;
              press_cnt <= '0;
            end
            // Next column, bit 3 is column 0
            col <= {col[0], col[3:1]};
          end
        end
      end else if (sample) begin
        if (row == 4'b0000) begin
          if (rel_cnt == DEB_LAST) begin
            // Release accepted, resume scanning
            held    <= 1'b0;
            cur_key <= '0;
            rel_cnt <= '0;
            col     <= {col[0], col[3:1]};
          end else begin
            rel_cnt <= rel_cnt + 1'b1;
          end
        end else begin
          // Bounce while held
          rel_cnt <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: keypad_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_fsm (
  input  logic                  clk,
  input  logic                  nRst,
  input  keypad_pkg::key_code_t cur_key,
  input  logic                  strobe,
  letter_if.producer            letter
);

  keypad_pkg::tap_state_t state;
  keypad_pkg::tap_state_t next_state;
  keypad_pkg::key_code_t  prev_key;
  keypad_pkg::key_code_t  next_prev;
  keypad_pkg::ascii_t     cur_letter;
  keypad_pkg::ascii_t     next_letter;
  logic                   ready_q;
  logic                   is_letter;
  logic                   four_letter;

  // Keys 2 to 9 map to a nonzero letter
  assign is_letter = (keypad_pkg::letter_for(cur_key, keypad_pkg::S0) != 8'd0);

  // PQRS and WXYZ
  assign four_letter = (cur_key == keypad_pkg::KEY_7) || (cur_key == keypad_pkg::KEY_9);

  assign letter.ready = ready_q;
  assign letter.data  = cur_letter;

  // Word events act in the strobe cycle only
  assign letter.word_submit = strobe && (cur_key == keypad_pkg::KEY_SUBMIT_WORD);
  assign letter.game_end    = strobe && (cur_key == keypad_pkg::KEY_GAME_END);

  always_comb begin
    next_state  = state;
    next_letter = cur_letter;
    next_prev   = prev_key;

    if (state == keypad_pkg::DONE) begin
      // Letter went out last cycle
      next_state  = keypad_pkg::INIT;
      next_letter = 8'd0;
    end else if (strobe) begin
      case (cur_key)
        keypad_pkg::KEY_SUBMIT_LETTER: begin
          // Nothing to submit before the first tap
          if (state != keypad_pkg::INIT) begin
            next_state = keypad_pkg::DONE;
          end
        end
        keypad_pkg::KEY_CLEAR,
        keypad_pkg::KEY_SUBMIT_WORD,
        keypad_pkg::KEY_GAME_END: begin
          next_state  = keypad_pkg::INIT;
          next_letter = 8'd0;
        end
        keypad_pkg::KEY_1,
        keypad_pkg::KEY_A,
        keypad_pkg::KEY_B,
        keypad_pkg::KEY_D: begin
          // Unused keys
          next_state = state;
        end
        default: begin
          if (is_letter) begin
            if (cur_key == prev_key) begin
              // Same key again, step through its letters
              case (state)
                keypad_pkg::S0: next_state = keypad_pkg::S1;
                keypad_pkg::S1: next_state = keypad_pkg::S2;
                keypad_pkg::S2: begin
                  next_state = four_letter ? keypad_pkg::S3 : keypad_pkg::S0;
                end
                keypad_pkg::S3: next_state = keypad_pkg::S0;
                default:        next_state = keypad_pkg::S0;
              endcase
            end else begin
              // New key starts on its first letter
              next_state = keypad_pkg::S0;
            end
            next_prev   = cur_key;
            next_letter = keypad_pkg::letter_for(cur_key, next_state);
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge nRst) begin
    if (!nRst) begin
      state      <= keypad_pkg::INIT;
      prev_key   <= '0;
      cur_letter <= '0;
      ready_q    <= 1'b0;
    end else begin
      state      <= next_state;
      prev_key   <= next_prev;
      cur_letter <= next_letter;
      // Pulse together with entry to DONE
      ready_q    <= (next_state == keypad_pkg::DONE);
    end
  end

endmodule

`default_nettype wire

// File: word_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module word_buffer #(
  parameter int MAX_LEN = 8
) (
  input  logic                          clk,
  input  logic                          nRst,
  letter_if.consumer                    letter,
  output logic                          word_valid,
  output logic [MAX_LEN*8-1:0]          word,
  output logic [$clog2(MAX_LEN+1)-1:0]  word_len,
  output logic                          game_over
);

  localparam int LW = $clog2(MAX_LEN + 1);
  localparam logic [LW-1:0] LEN_FULL = LW'(MAX_LEN);

  // Letters collected so far, letter 0 in the low byte
  logic [MAX_LEN*8-1:0] acc;
  logic [LW-1:0]        count;
  logic                 has_room;

  assign has_room = (count < LEN_FULL);

  always_ff @(posedge clk or negedge nRst) begin
    if (!nRst) begin
      acc        <= '0;
      count      <= '0;
      word       <= '0;
      word_len   <= '0;
      word_valid <= 1'b0;
      game_over  <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      game_over  <= 1'b0;
      if (letter.word_submit) begin
        // Present the finished word, start a new one
        word       <= acc;
        word_len   <= count;
        word_valid <= 1'b1;
        acc        <= '0;
        count      <= '0;
      end else if (letter.game_end) begin
        // Partial word is discarded
        game_over  <= 1'b1;
        acc        <= '0;
        count      <= '0;
      end else if (letter.ready && has_room) begin
        acc[count*8 +: 8] <= letter.data;
        count             <= count + 1'b1;
      end
      // Full buffer drops further letters
    end
  end

endmodule

`default_nettype wire

// File: keypad_word_top.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_word_top #(
  parameter int SCAN_DWELL     = 4,
  parameter int DEBOUNCE_SCANS = 2,
  parameter int MAX_LEN        = 8
) (
  input  logic                          clk,
  input  logic                          nRst,
  input  logic [3:0]                    row,
  output logic [3:0]                    col,
  output keypad_pkg::ascii_t            preview,
  output logic                          letter_valid,
  output keypad_pkg::ascii_t            letter,
  output logic                          word_valid,
  output logic [MAX_LEN*8-1:0]          word,
  output logic [$clog2(MAX_LEN+1)-1:0]  word_len,
  output logic                          game_over
);

  keypad_pkg::key_code_t cur_key;
  logic                  strobe;

  // Letter and word events to the buffer
  letter_if letter_bus ();

  keypad_scanner #(
    .SCAN_DWELL     (SCAN_DWELL),
    .DEBOUNCE_SCANS (DEBOUNCE_SCANS)
  ) u_scanner (
    .clk     (clk),
    .nRst    (nRst),
    .row     (row),
    .col     (col),
    .cur_key (cur_key),
    .strobe  (strobe)
  );

  keypad_fsm u_fsm (
    .clk     (clk),
    .nRst    (nRst),
    .cur_key (cur_key),
    .strobe  (strobe),
    .letter  (letter_bus.producer)
  );

  word_buffer #(
    .MAX_LEN (MAX_LEN)
  ) u_buffer (
    .clk        (clk),
    .nRst       (nRst),
    .letter     (letter_bus.consumer),
    .word_valid (word_valid),
    .word       (word),
    .word_len   (word_len),
    .game_over  (game_over)
  );

  // Preview and submitted letter share the same register
  assign preview      = letter_bus.data;
  assign letter       = letter_bus.data;
  assign letter_valid = letter_bus.ready;

endmodule

`default_nettype wire

// File: keypad_properties.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_properties #(
  parameter int MAX_LEN = 8
) (
  input logic                          clk,
  input logic                          nRst,
  input logic [3:0]                    col,
  input logic                          letter_valid,
  input logic                          word_valid,
  input logic [$clog2(MAX_LEN+1)-1:0]  word_len
);

  localparam int LW = $clog2(MAX_LEN + 1);
  localparam logic [LW-1:0] LEN_MAX = LW'(MAX_LEN);

  // Exactly one column driven at a time
  col_onehot: assert property (@(posedge clk) disable iff (!nRst) $onehot(col))
    else $error("col is not one-hot");

  // Letter output is a single-cycle pulse
  letter_pulse: assert property (@(posedge clk) disable iff (!nRst)
    letter_valid |=> !letter_valid)
    else $error("letter_valid high for two cycles");

  // Saturates at the buffer size
  len_bound: assert property (@(posedge clk) disable iff (!nRst) word_len <= LEN_MAX)
    else $error("word_len above MAX_LEN");

  // Letter and word events never coincide
  valid_excl: assert property (@(posedge clk) disable iff (!nRst)
    !(letter_valid && word_valid))
    else $error("letter_valid and word_valid together");

endmodule

bind keypad_word_top keypad_properties #(
  .MAX_LEN (MAX_LEN)
) u_props (
  .clk          (clk),
  .nRst         (nRst),
  .col          (col),
  .letter_valid (letter_valid),
  .word_valid   (word_valid),
  .word_len     (word_len)
);

`default_nettype wire

// File: tb_keypad_word.sv
`timescale 1ns/10ps
`default_nettype none

module tb_keypad_word;

  localparam int SCAN_DWELL     = 4;
  localparam int DEBOUNCE_SCANS = 2;
  localparam int MAX_LEN        = 8;
  localparam int LW             = $clog2(MAX_LEN + 1);
  // Column comes round DEBOUNCE_SCANS times plus one spare scan
  localparam int PRESS_LIMIT    = 4 * SCAN_DWELL * (DEBOUNCE_SCANS + 2);
  // Frozen column is sampled every dwell
  localparam int RELEASE_LIMIT  = SCAN_DWELL * (DEBOUNCE_SCANS + 2);
  // Upper bound on key presses over all tests
  localparam int PRESS_COUNT    = 80;
  localparam int WATCHDOG       = 16 + PRESS_COUNT * (PRESS_LIMIT + RELEASE_LIMIT + 4) + 200;

  logic                  clk = 1'b0;
  logic                  nRst = 1'b0;
  logic [3:0]            row = 4'b0000;
  logic [3:0]            col;
  keypad_pkg::ascii_t    preview;
  logic                  letter_valid;
  keypad_pkg::ascii_t    letter;
  logic                  word_valid;
  logic [MAX_LEN*8-1:0]  word;
  logic [LW-1:0]         word_len;
  logic                  game_over;

  // Key held down or zero for none
  keypad_pkg::key_code_t pressed = '0;
  // Outputs one cycle after the press strobe
  keypad_pkg::ascii_t    cap_preview;
  logic                  cap_letter_valid;
  keypad_pkg::ascii_t    cap_letter;
  logic                  cap_word_valid;
  logic [MAX_LEN*8-1:0]  cap_word;
  logic [LW-1:0]         cap_len;
  logic                  cap_game_over;
  logic [31:0]           rng = 32'h56f9_2f56;

  // Keys 2 to 9 with first letter and number of letters
  keypad_pkg::key_code_t letter_keys [8] = '{8'h84, 8'h82, 8'h48, 8'h44,
                                             8'h42, 8'h28, 8'h24, 8'h22};
  keypad_pkg::ascii_t    first_letter [8] = '{"A", "D", "G", "J", "M", "P", "T", "W"};
  int                    letter_count [8] = '{3, 3, 3, 3, 3, 4, 3, 4};
  keypad_pkg::key_code_t dead_keys [4] = '{keypad_pkg::KEY_1, keypad_pkg::KEY_A,
                                           keypad_pkg::KEY_B, keypad_pkg::KEY_D};

  keypad_word_top #(
    .SCAN_DWELL     (SCAN_DWELL),
    .DEBOUNCE_SCANS (DEBOUNCE_SCANS),
    .MAX_LEN        (MAX_LEN)
  ) uut (.*);

  initial begin
    forever #20 clk = ~clk;
  end

  // Held key connects its row to its column
  always @(negedge clk) begin
    if ((pressed[3:0] & col) != 4'b0000) begin
      row <= pressed[7:4];
    end else begin
      row <= 4'b0000;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Letters wrap after the last one on the key
  function automatic keypad_pkg::ascii_t expected_letter(input int idx, input int taps);
    return first_letter[idx] + keypad_pkg::ascii_t'((taps - 1) % letter_count[idx]);
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_letter(input string test, input keypad_pkg::ascii_t exp,
                              input keypad_pkg::ascii_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic check_word(input string test, input logic [MAX_LEN*8-1:0] exp_word,
                            input logic [LW-1:0] exp_len, input logic [MAX_LEN*8-1:0] act_word,
                            input logic [LW-1:0] act_len);
    if ((act_word !== exp_word) || (act_len !== exp_len)) begin
      stop_on_error($sformatf("[FAIL] %s: expected %0d letters %h, actual %0d letters %h",
                              test, exp_len, exp_word, act_len, act_word));
    end
  endtask

  task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: expected %b, actual %b", test, exp, act));
    end
  endtask

  // Hold a key until the scanner strobes, then capture and release
  task automatic tap(input keypad_pkg::key_code_t key);
    int n;
    n = 0;
    pressed <= key;
    @(negedge clk);
    while ((uut.strobe !== 1'b1) && (n < PRESS_LIMIT)) begin
      @(negedge clk);
      n++;
    end
    if (uut.strobe !== 1'b1) begin
      stop_on_error($sformatf("Key %h was never accepted by the scanner", key));
    end
    // Edge after the strobe has registered the response
    @(negedge clk);
    cap_preview      = preview;
    cap_letter_valid = letter_valid;
    cap_letter       = letter;
    cap_word_valid   = word_valid;
    cap_word         = word;
    cap_len          = word_len;
    cap_game_over    = game_over;
    pressed <= '0;
    n = 0;
    while ((uut.cur_key !== 8'h00) && (n < RELEASE_LIMIT)) begin
      @(negedge clk);
      n++;
    end
    if (uut.cur_key !== 8'h00) begin
      stop_on_error($sformatf("Release of key %h was never accepted", key));
    end
  endtask

  task automatic tap_times(input int idx, input int taps);
    for (int i = 0; i < taps; i++) begin
      tap(letter_keys[idx]);
    end
  endtask

  // Submit the previewed letter and expect it on the letter port
  task automatic submit_letter(input string test, input keypad_pkg::ascii_t exp);
    tap(keypad_pkg::KEY_SUBMIT_LETTER);
    check_flag(test, 1'b1, cap_letter_valid);
    check_letter(test, exp, cap_letter);
  endtask

  // PQRS wraps after four taps and TUV after three
  task automatic multitap_cycling();
    for (int t = 1; t <= 5; t++) begin
      tap(letter_keys[5]);
      check_letter("multitap key 7", expected_letter(5, t), cap_preview);
    end
    for (int t = 1; t <= 4; t++) begin
      tap(letter_keys[6]);
      check_letter("multitap key 8", expected_letter(6, t), cap_preview);
    end
  endtask

  task automatic letter_submission();
    logic [MAX_LEN*8-1:0] exp_word;
    tap_times(0, 2);
    submit_letter("submit letter", expected_letter(0, 2));
    check_letter("preview after submit", 8'd0, preview);
    // Nothing tapped since the submit
    tap(keypad_pkg::KEY_SUBMIT_LETTER);
    check_flag("submit in INIT", 1'b0, cap_letter_valid);
    tap(keypad_pkg::KEY_SUBMIT_WORD);
    exp_word = '0;
    exp_word[7:0] = expected_letter(0, 2);
    check_flag("one letter word valid", 1'b1, cap_word_valid);
    check_word("one letter word", exp_word, LW'(1), cap_word, cap_len);
  endtask

  task automatic invalid_and_clear();
    tap(letter_keys[3]);
    for (int i = 0; i < 4; i++) begin
      tap(dead_keys[i]);
      check_letter("dead key preview", expected_letter(3, 1), cap_preview);
      check_flag("dead key letter", 1'b0, cap_letter_valid);
    end
    tap(keypad_pkg::KEY_CLEAR);
    check_letter("clear preview", 8'd0, cap_preview);
    check_flag("clear letter", 1'b0, cap_letter_valid);
  endtask

  task automatic word_assembly();
    logic [MAX_LEN*8-1:0] exp_word;
    int idx;
    int taps;
    exp_word = '0;
    for (int k = 0; k < 5; k++) begin
      rng  = xorshift(rng);
      idx  = int'(rng % 8);
      rng  = xorshift(rng);
      taps = 1 + int'(rng % letter_count[idx]);
      tap_times(idx, taps);
      submit_letter("random letter", expected_letter(idx, taps));
      exp_word[k*8 +: 8] = expected_letter(idx, taps);
    end
    tap(keypad_pkg::KEY_SUBMIT_WORD);
    check_flag("random word valid", 1'b1, cap_word_valid);
    check_word("random word", exp_word, LW'(5), cap_word, cap_len);
    // Buffer emptied by the submit
    tap_times(1, 1);
    submit_letter("second word letter", expected_letter(1, 1));
    tap(keypad_pkg::KEY_SUBMIT_WORD);
    exp_word = '0;
    exp_word[7:0] = expected_letter(1, 1);
    check_flag("second word valid", 1'b1, cap_word_valid);
    check_word("second word", exp_word, LW'(1), cap_word, cap_len);
  endtask

  task automatic buffer_overflow();
    logic [MAX_LEN*8-1:0] exp_word;
    exp_word = '0;
    for (int k = 0; k < MAX_LEN + 2; k++) begin
      tap_times(k % 8, 1);
      submit_letter("overflow letter", expected_letter(k % 8, 1));
      if (k < MAX_LEN) begin
        exp_word[k*8 +: 8] = expected_letter(k % 8, 1);
      end
    end
    tap(keypad_pkg::KEY_SUBMIT_WORD);
    check_flag("full word valid", 1'b1, cap_word_valid);
    check_word("full word", exp_word, LW'(MAX_LEN), cap_word, cap_len);
  endtask

  task automatic game_end_discard();
    tap_times(2, 1);
    submit_letter("letter before game end", expected_letter(2, 1));
    tap_times(4, 2);
    tap(keypad_pkg::KEY_GAME_END);
    check_flag("game over pulse", 1'b1, cap_game_over);
    check_letter("preview after game end", 8'd0, cap_preview);
    tap(keypad_pkg::KEY_SUBMIT_WORD);
    check_flag("empty word valid", 1'b1, cap_word_valid);
    check_word("empty word", '0, '0, cap_word, cap_len);
  endtask

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    stop_on_error("Watchdog expired before the tests finished");
  end

  initial begin
    repeat (16) @(negedge clk);
    nRst = 1'b1;
    @(negedge clk);
    check_flag("reset column", 1'b1, col == 4'b1000);
    check_letter("reset preview", 8'd0, preview);
    multitap_cycling();
    letter_submission();
    invalid_and_clear();
    word_assembly();
    buffer_overflow();
    game_end_discard();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
keypad_pkg.sv
letter_if.sv
keypad_scanner.sv
keypad_fsm.sv
word_buffer.sv
keypad_word_top.sv
keypad_properties.sv
tb_keypad_word.sv

// File: Makefile
TOP = tb_keypad_word

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
